//--- src.f
src/video_pkg.sv
src/cam_pixel_packer.sv
src/video_source_combiner.sv
src/dual_cam_video_top.sv
test/dual_cam_video_assertions.sv
test/dual_cam_video_tb.sv

//--- src/cam_pixel_packer.sv
// camera pixel packer, pairs rgb565 sensor bytes into registered 16-bit words with aligned vsync
module cam_pixel_packer
(
    input  logic                 video_clk,
    input  logic                 reset_n,
    input  video_pkg::cam_bus_t  cam_i,        // byte stream from one sensor
    output video_pkg::cam_word_t word_o        // packed word to the combiner
);

    // ========================================================================
    // byte pairing state
    // ========================================================================
    logic                                phase_q;    // 0 expects hi byte, 1 expects lo
    logic                                take_hi;    // this byte starts a pair
    logic                                take_lo;    // this byte closes a pair
    logic [video_pkg::CAM_BYTE_W-1:0]    hi_q;       // held first byte
    logic                                valid_q;    // word register holds a fresh word
    logic                                vsync_q;    // camera vsync, one cycle late
    video_pkg::pix565_u                  word_q;     // assembled pixel

    // bytes only count while href is up
    assign take_hi = cam_i.href && !phase_q;
    assign take_lo = cam_i.href &&  phase_q;

    // ========================================================================
    // control registers
    // ========================================================================
    // phase toggles on each accepted byte and falls back to hi whenever href
    // drops, so a lone byte at the end of a line is simply forgotten
    always_ff @(posedge video_clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            phase_q <= 1'b0;                     // start on a hi byte
            valid_q <= 1'b0;
            vsync_q <= 1'b0;
        end
        else
        begin
            phase_q <= take_hi;                  // lo byte or idle line returns to hi
            valid_q <= take_lo;                  // one cycle pulse per word
            vsync_q <= cam_i.vsync;              // same delay as the word
        end
    end

    // ========================================================================
    // payload registers
    // ========================================================================
    always_ff @(posedge video_clk)
    begin
        if (take_hi)
        begin
            hi_q <= cam_i.data;                  // keep first byte of the pair
        end
        if (take_lo)
        begin
            word_q.bytes.hi <= hi_q;             // earlier byte goes on top
            word_q.bytes.lo <= cam_i.data;       // current byte below
        end
    end

    // ========================================================================
    // output word
    // ========================================================================
    // word, flag and vsync all come straight from registers so the
    // combiner sees them on the same cycle
    assign word_o.valid = valid_q;
    assign word_o.vsync = vsync_q;
    assign word_o.word  = word_q;

endmodule

//--- src/dual_cam_video_top.sv
// dual camera video top, two byte packers feeding one source combiner
module dual_cam_video_top
(
    input  logic                  video_clk,
    input  logic                  reset_n,
    input  video_pkg::cam_bus_t   cam0_i,         // camera 0 byte bus
    input  video_pkg::cam_bus_t   cam1_i,         // camera 1 byte bus
    input  logic                  sel_i,          // camera select, applied in vblank
    output video_pkg::video_out_t video_o         // 24-bit pixel stream out
);

    // ========================================================================
    // packer to combiner words
    // ========================================================================
    video_pkg::cam_word_t cam0_word;              // camera 0 packed words
    video_pkg::cam_word_t cam1_word;              // camera 1 packed words

    // ========================================================================
    // camera packers
    // ========================================================================
    cam_pixel_packer u_cam0_packer
    (
        .video_clk   (video_clk),
        .reset_n     (reset_n),
        .cam_i       (cam0_i),
        .word_o      (cam0_word)
    );

    cam_pixel_packer u_cam1_packer
    (
        .video_clk   (video_clk),
        .reset_n     (reset_n),
        .cam_i       (cam1_i),
        .word_o      (cam1_word)
    );

    // ========================================================================
    // source choice and colour expansion
    // ========================================================================
    // one register stage here, one in each packer, two cycles in total
    video_source_combiner u_combiner
    (
        .video_clk   (video_clk),
        .reset_n     (reset_n),
        .sel_i       (sel_i),
        .cam0_word_i (cam0_word),
        .cam1_word_i (cam1_word),
        .video_o     (video_o)
    );

endmodule

//--- src/video_pkg.sv
// video package, shared widths, fill colour and port types for the dual camera video path
package video_pkg;

    // ========================================================================
    // widths and constants
    // ========================================================================
    localparam int CAM_BYTE_W = 8;                      // one sensor data byte
    localparam int PIX565_W   = 16;                     // one packed camera pixel
    localparam int RGB888_W   = 24;                     // one output pixel
    localparam int NUM_CAMS   = 2;                      // camera inputs, 1 bit select

    localparam logic [RGB888_W-1:0] FILL_RGB = 24'h0F550F; // colour outside active data

    // ========================================================================
    // camera input bus
    // ========================================================================
    typedef struct packed {
        logic [CAM_BYTE_W-1:0] data;                    // byte from the sensor
        logic                  href;                    // line active
        logic                  vsync;                   // high in vertical blanking
    } cam_bus_t;

    // ========================================================================
    // one camera word, seen as two bytes or as rgb565 fields
    // ========================================================================
    typedef struct packed {
        logic [PIX565_W/2-1:0] hi;                      // first byte of the pair
        logic [PIX565_W/2-1:0] lo;                      // second byte
    } pix_bytes_t;

    typedef struct packed {
        logic [4:0] r;                                  // red in the top bits
        logic [5:0] g;
        logic [4:0] b;                                  // blue at the bottom
    } pix_rgb565_t;

    typedef union packed {
        pix_bytes_t  bytes;                             // arrival order view
        pix_rgb565_t rgb565;                            // colour field view
    } pix565_u;

    typedef struct packed {
        logic    valid;                                 // word present
        logic    vsync;                                 // vsync aligned to the word
        pix565_u word;
    } cam_word_t;

    // ========================================================================
    // output pixel and output bus
    // ========================================================================
    typedef struct packed {
        logic [RGB888_W/3-1:0] ch_hi;                   // expanded blue
        logic [RGB888_W/3-1:0] ch_mid;                  // expanded green
        logic [RGB888_W/3-1:0] ch_lo;                   // expanded red
    } rgb888_t;

    typedef struct packed {
        logic    de;                                    // pixel valid
        logic    vsync;
        rgb888_t rgb;
    } video_out_t;

endpackage

//--- src/video_source_combiner.sv
// video source combiner, picks the active camera at frame edges and expands rgb565 to 24-bit
module video_source_combiner
(
    input  logic                  video_clk,
    input  logic                  reset_n,
    input  logic                  sel_i,          // 0 camera 0, 1 camera 1
    input  video_pkg::cam_word_t  cam0_word_i,    // from camera 0 packer
    input  video_pkg::cam_word_t  cam1_word_i,    // from camera 1 packer
    output video_pkg::video_out_t video_o         // 24-bit pixel stream
);

    // ========================================================================
    // source selection
    // ========================================================================
    logic [$clog2(video_pkg::NUM_CAMS)-1:0] active_src_q;          // camera now on the output
    video_pkg::cam_word_t                   cam_words [video_pkg::NUM_CAMS];
    video_pkg::cam_word_t                   cur_word;              // word of the active camera
    logic                                   src_blank;             // active camera in vblank
    video_pkg::rgb888_t                     pix_rgb;               // expanded active word

    assign cam_words[0] = cam0_word_i;
    assign cam_words[1] = cam1_word_i;

    assign cur_word  = cam_words[active_src_q];  // mux by registered source
    assign src_blank = cur_word.vsync;           // safe point to switch

    // ========================================================================
    // rgb565 to rgb888 expansion
    // ========================================================================
    // fields are padded with zero low bits and placed blue, green, red from
    // the top byte down
    function automatic video_pkg::rgb888_t expand_565(input video_pkg::pix565_u pix);
        video_pkg::rgb888_t px;
        px.ch_hi  = {pix.rgb565.b, 3'b000};      // blue on top
        px.ch_mid = {pix.rgb565.g, 2'b00};       // green in the middle
        px.ch_lo  = {pix.rgb565.r, 3'b000};      // red at the bottom
        return px;
    endfunction

    assign pix_rgb = expand_565(cur_word.word);

    // ========================================================================
    // active source register
    // ========================================================================
    // the select is only looked at while the current source is blanking,
    // so a request mid frame waits for the next vertical blanking
    always_ff @(posedge video_clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            active_src_q <= '0;                  // camera 0 after reset
        end
        else if (src_blank)
        begin
            active_src_q <= sel_i;               // take request in vblank
        end
    end

    // ========================================================================
    // output register
    // ========================================================================
    logic               de_q;
    logic               vsync_q;
    video_pkg::rgb888_t rgb_q;

    always_ff @(posedge video_clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            de_q    <= 1'b0;
            vsync_q <= 1'b0;
            rgb_q   <= video_pkg::FILL_RGB;      // fill colour until first pixel
        end
        else
        begin
            de_q    <= cur_word.valid;           // de follows the word flag
            vsync_q <= cur_word.vsync;           // vsync of the shown camera
            if (cur_word.valid)
            begin
                rgb_q <= pix_rgb;
            end
            else
            begin
                rgb_q <= video_pkg::FILL_RGB;    // blanking and line gaps
            end
        end
    end

    assign video_o.de    = de_q;
    assign video_o.vsync = vsync_q;
    assign video_o.rgb   = rgb_q;

endmodule

//--- test/dual_cam_video_assertions.sv
// output stream assertions for the dual camera video top, bound into the design
module dual_cam_video_assertions
(
    input logic                  video_clk,
    input logic                  reset_n,
    input video_pkg::cam_bus_t   cam0_i,
    input video_pkg::cam_bus_t   cam1_i,
    input logic                  active_src_i,   // combiner source register
    input video_pkg::video_out_t video_i         // top level output
);

    // fill colour whenever no pixel is flagged
    fill_when_idle: assert property (@(posedge video_clk) disable iff (!reset_n)
        !video_i.de |-> video_i.rgb == video_pkg::FILL_RGB)
        else $error("rgb is not the fill colour while de is low");

    // second reset edge onward, outputs held quiet
    quiet_in_reset: assert property (@(posedge video_clk)
        (!reset_n ##1 !reset_n) |-> (!video_i.de && !video_i.vsync))
        else $error("de or vsync high during reset");

    // ========================================================================
    // vsync latency, two cycles from camera pin to output
    // ========================================================================
    cam0_vsync_path: assert property (@(posedge video_clk) disable iff (!reset_n)
        (active_src_i == 1'b0) |=> (video_i.vsync == $past(cam0_i.vsync, 2)))
        else $error("camera 0 vsync not on the output two cycles later");

    cam1_vsync_path: assert property (@(posedge video_clk) disable iff (!reset_n)
        (active_src_i == 1'b1) |=> (video_i.vsync == $past(cam1_i.vsync, 2)))
        else $error("camera 1 vsync not on the output two cycles later");

endmodule

bind dual_cam_video_top dual_cam_video_assertions u_assertions
(
    .video_clk    (video_clk),
    .reset_n      (reset_n),
    .cam0_i       (cam0_i),
    .cam1_i       (cam1_i),
    .active_src_i (u_combiner.active_src_q),
    .video_i      (video_o)
);

//--- test/dual_cam_video_tb.sv
// dual camera video testbench, drives both camera buses and checks the 24-bit output stream
module dual_cam_video_tb;

    localparam int MAX_CYCLES = 4000;            // about twice the stimulus length

    logic                  video_clk;
    logic                  reset_n;
    video_pkg::cam_bus_t   cam0_i;
    video_pkg::cam_bus_t   cam1_i;
    logic                  sel_i;
    video_pkg::video_out_t video_o;

    video_pkg::video_out_t exp_q [$];            // expected output, one entry per edge
    int                    errors;
    int                    checks;
    int                    err_start;            // errors at start of the current test
    int                    de_count;             // pixels seen with de high
    int                    cycles;

    // model state, one slot per camera
    logic       m_phase [2];                     // 0 waits for hi byte
    logic [7:0] m_hi    [2];
    logic       m_valid [2];                     // word leaving the pairing stage
    logic       m_vsync [2];
    logic [15:0] m_word [2];
    logic       m_src;                           // camera shown on the output

    dual_cam_video_top i_dut
    (
        .video_clk (video_clk),
        .reset_n   (reset_n),
        .cam0_i    (cam0_i),
        .cam1_i    (cam1_i),
        .sel_i     (sel_i),
        .video_o   (video_o)
    );

    initial
    begin
        video_clk = 1'b0;
        forever
        begin
            #5 video_clk = ~video_clk;
        end
    end

    // ========================================================================
    // reference model and checking
    // ========================================================================
    // rgb565 word to 24-bit pixel, blue on top, red at the bottom
    function automatic logic [23:0] expected_rgb(input logic [15:0] w);
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
        r = w[15:11];
        g = w[10:5];
        b = w[4:0];
        return {b, 3'b000, g, 2'b00, r, 3'b000};  // low bits padded with zeros
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %s got %0h expected %0h at cycle %0d", name, got, exp, cycles);
        end
    endtask

    // first byte with href is hi, next is lo, a lone hi byte is dropped
    task automatic pair_bytes(input int c, input video_pkg::cam_bus_t cam);
        if (cam.href && !m_phase[c])
        begin
            m_hi[c]    = cam.data;
            m_phase[c] = 1'b1;
            m_valid[c] = 1'b0;
        end
        else if (cam.href)
        begin
            m_word[c]  = {m_hi[c], cam.data};    // first byte on top
            m_phase[c] = 1'b0;
            m_valid[c] = 1'b1;
        end
        else
        begin
            m_phase[c] = 1'b0;                   // line gap, back to hi
            m_valid[c] = 1'b0;
        end
        m_vsync[c] = cam.vsync;
    endtask

    always @(posedge video_clk)
    begin : compare_and_model
        video_pkg::video_out_t expv;
        video_pkg::video_out_t nxt;
        cycles++;
        if (exp_q.size() > 0)                    // empty only on the very first edge
        begin
            expv = exp_q.pop_front();
            check_value("video_o.de", video_o.de, expv.de);
            check_value("video_o.vsync", video_o.vsync, expv.vsync);
            check_value("video_o.rgb", video_o.rgb, expv.rgb);
            if (video_o.de)
            begin
                de_count++;
            end
        end
        if (!reset_n)
        begin
            m_phase   = '{2{1'b0}};
            m_valid   = '{2{1'b0}};
            m_vsync   = '{2{1'b0}};
            m_src     = 1'b0;                    // camera 0 after reset
            nxt.de    = 1'b0;
            nxt.vsync = 1'b0;
            nxt.rgb   = video_pkg::FILL_RGB;
        end
        else
        begin
            // output stage uses words paired on the previous edge
            nxt.de    = m_valid[m_src];
            nxt.vsync = m_vsync[m_src];
            nxt.rgb   = m_valid[m_src] ? expected_rgb(m_word[m_src]) : video_pkg::FILL_RGB;
            if (m_vsync[m_src])
            begin
                m_src = sel_i;                   // source only moves in blanking
            end
            pair_bytes(0, cam0_i);
            pair_bytes(1, cam1_i);
        end
        exp_q.push_back(nxt);
    end

    // ========================================================================
    // stimulus tasks
    // ========================================================================
    task automatic send_line(input int n_bytes, input bit cam0_on, input bit cam1_on);
        repeat (n_bytes)
        begin
            @(negedge video_clk);
            cam0_i.href = cam0_on;
            cam0_i.data = $urandom_range(255);
            cam1_i.href = cam1_on;
            cam1_i.data = $urandom_range(255);
        end
        @(negedge video_clk);
        cam0_i.href = 1'b0;
        cam1_i.href = 1'b0;
        repeat (3) @(negedge video_clk);         // horizontal gap
    endtask

    task automatic send_lines(input int count, input bit odd, input bit cam0_on,
                              input bit cam1_on, inout int pixels);
        int n;
        repeat (count)
        begin
            n = 2 * (2 + $urandom_range(18)) + odd;
            send_line(n, cam0_on, cam1_on);
            pixels += n / 2;                     // trailing odd byte gives nothing
        end
    endtask

    task automatic send_vblank(input logic new_sel);
        @(negedge video_clk);
        cam0_i.vsync = 1'b1;
        @(negedge video_clk);
        cam1_i.vsync = 1'b1;                     // camera 1 blanking a cycle behind
        @(negedge video_clk);
        sel_i = new_sel;                         // request lands inside the blanking
        repeat (4) @(negedge video_clk);
        cam0_i.vsync = 1'b0;
        repeat (2) @(negedge video_clk);
        cam1_i.vsync = 1'b0;                     // and ending two cycles later
        repeat (2) @(negedge video_clk);
    endtask

    task automatic finish_test(input string name, input int exp_pixels);
        repeat (4) @(negedge video_clk);         // drain the two stage pipeline
        check_value("de_count", de_count, exp_pixels);
        $display("test %s: %0d pixels, %0d mismatches", name, de_count, errors - err_start);
        de_count  = 0;
        err_start = errors;
    endtask

    initial
    begin : watchdog
        int n;
        n = 0;
        while (n < MAX_CYCLES)
        begin
            @(posedge video_clk);
            n++;
        end
        $display("timeout: stimulus still running after %0d cycles", n);
        $display("Verification failed");
        $finish;
    end

    // ========================================================================
    // test sequence
    // ========================================================================
    initial
    begin : stimulus
        int pix;
        int ignored;
        errors    = 0;
        checks    = 0;
        err_start = 0;
        de_count  = 0;
        cycles    = 0;
        ignored   = 0;
        void'($urandom(20898));
        reset_n = 1'b0;
        sel_i   = 1'b0;
        cam0_i  = '0;
        cam1_i  = '0;
        repeat (10) @(negedge video_clk);
        reset_n = 1'b1;
        finish_test("1 reset state", 0);

        pix = 0;
        repeat (3)
        begin
            send_lines(8, 1'b0, 1'b1, 1'b1, pix);
            send_vblank(1'b0);
        end
        finish_test("2 packing on camera 0", pix);

        pix = 0;
        send_lines(4, 1'b1, 1'b1, 1'b1, pix);  // odd lines
        send_lines(2, 1'b0, 1'b1, 1'b1, pix);  // then even ones from the first byte
        finish_test("3 odd trailing byte", pix);

        pix = 0;
        send_lines(2, 1'b0, 1'b1, 1'b1, pix);
        send_vblank(1'b1);                       // switch to camera 1 in blanking
        send_lines(5, 1'b0, 1'b1, 1'b1, pix);
        finish_test("4 switch in blanking", pix);

        pix = 0;
        send_lines(2, 1'b0, 1'b1, 1'b1, pix);
        sel_i = 1'b0;                            // mid frame, camera 1 stays
        send_lines(3, 1'b0, 1'b1, 1'b1, pix);
        send_vblank(1'b0);
        send_lines(2, 1'b0, 1'b1, 1'b1, pix);
        finish_test("5 mid-frame switch request", pix);

        // camera 0 stays idle while camera 1 carries traffic
        send_lines(3, 1'b0, 1'b0, 1'b1, ignored);
        send_vblank(1'b0);
        send_lines(2, 1'b0, 1'b0, 1'b1, ignored);
        finish_test("6 blanking fill", 0);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
